/* hw/acc_pkg.sv */
/*
 * Shared definitions for the accelerator offload interconnect:
 * widths and level constants, vector typedefs, the C request and
 * response payload structs, the spill register states and the hart id table
 */

`default_nettype none

package acc_pkg;

  ////////////////////////////////////////
  // Sizes and addressing
  ////////////////////////////////////////

  localparam int unsigned NUM_REQ         = 2;
  localparam int unsigned NUM_RSP         = 2;
  localparam int unsigned HIER_ADDR_WIDTH = 2;
  localparam int unsigned ACC_ADDR_WIDTH  = 6;
  localparam int unsigned ADDR_WIDTH      = HIER_ADDR_WIDTH + ACC_ADDR_WIDTH;
  localparam int unsigned DATA_WIDTH      = 32;

  // Level number served by this instance
  localparam int unsigned HIER_LEVEL      = 1;

  // Low accelerator-address bits that pick the unit
  localparam int unsigned RSP_SEL_WIDTH   = 1;
  localparam int unsigned REQ_IDX_WIDTH   = 1;
  localparam int unsigned HART_ID_WIDTH   = 4;
  localparam int unsigned HART_ID_BASE    = 4;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  // Level field occupies the top bits
  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [HART_ID_WIDTH-1:0]   hart_id_t;
  typedef logic [HIER_ADDR_WIDTH-1:0] level_t;
  typedef logic [RSP_SEL_WIDTH-1:0]   rsp_sel_t;
  typedef logic [REQ_IDX_WIDTH-1:0]   req_idx_t;

  ////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////

  typedef struct packed {
    addr_t    addr;
    hart_id_t hart_id;
    data_t    instr;
    data_t    rs1;
  } c_req_t;

  typedef struct packed {
    hart_id_t hart_id;
    data_t    result;
    logic     error;
  } c_rsp_t;

  // Fill level of a two-entry spill register
  typedef enum logic [1:0] {
    SPILL_EMPTY = 2'd0,
    SPILL_ONE   = 2'd1,
    SPILL_TWO   = 2'd2
  } spill_state_e;

  // Fixed hart id per requester, entry i is HART_ID_BASE + i
  localparam hart_id_t [NUM_REQ-1:0] HART_ID_TABLE = {
    hart_id_t'(HART_ID_BASE + 1),
    hart_id_t'(HART_ID_BASE)
  };

endpackage

`default_nettype wire

/* hw/acc_rr_arbiter.sv */
/*
 * Round-robin arbiter for valid/ready streams with payload mux.
 * The grant is held while the output waits for ready.
 */

`timescale 1ns/1ps
`default_nettype none

module acc_rr_arbiter #(
  parameter int unsigned NUM_INP   = 2,
  parameter type         payload_t = logic
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  payload_t [NUM_INP-1:0]        inp_i,
  input  logic     [NUM_INP-1:0]        inp_valid_i,
  output logic     [NUM_INP-1:0]        inp_ready_o,
  output payload_t                      oup_o,
  output logic                          oup_valid_o,
  input  logic                          oup_ready_i,
  output acc_pkg::req_idx_t             oup_idx_o
);

  acc_pkg::req_idx_t rr_q;
  acc_pkg::req_idx_t held_q;
  logic              lock_q;
  acc_pkg::req_idx_t grant;

  // First valid input at or after the pointer, unless a grant is held
  always_comb begin
    int cand;
    grant = rr_q;
    for (int off = NUM_INP - 1; off >= 0; off--) begin
      cand = (int'(rr_q) + off) % NUM_INP;
      if (inp_valid_i[cand]) begin
        grant = acc_pkg::req_idx_t'(cand);
      end
    end
    if (lock_q) begin
      grant = held_q;
    end
  end

  assign oup_o       = inp_i[grant];
  assign oup_valid_o = inp_valid_i[grant];
  assign oup_idx_o   = grant;

  for (genvar i = 0; i < NUM_INP; i++) begin : gen_ready
    assign inp_ready_o[i] = oup_ready_i && (grant == i);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q   <= '0;
      held_q <= '0;
      lock_q <= 1'b0;
    end else begin
      // Stall keeps the current winner
      lock_q <= oup_valid_o && !oup_ready_i;
      held_q <= grant;
      if (oup_valid_o && oup_ready_i) begin
        rr_q <= acc_pkg::req_idx_t'((int'(grant) + 1) % NUM_INP);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/acc_spill_reg.sv */
/*
 * Two-entry spill register on a valid/ready stream.
 * Registered ready, full throughput, oldest entry at the output.
 */

`timescale 1ns/1ps
`default_nettype none

module acc_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  acc_pkg::spill_state_e state_q;
  payload_t              head_q;
  payload_t              tail_q;
  logic                  push;
  logic                  pop;

  assign ready_o = (state_q != acc_pkg::SPILL_TWO);
  assign valid_o = (state_q != acc_pkg::SPILL_EMPTY);
  assign data_o  = head_q;

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= acc_pkg::SPILL_EMPTY;
    end else begin
      case (state_q)
        acc_pkg::SPILL_EMPTY: if (push) state_q <= acc_pkg::SPILL_ONE;
        acc_pkg::SPILL_ONE: begin
          if (push && !pop) begin
            state_q <= acc_pkg::SPILL_TWO;
          end else if (pop && !push) begin
            state_q <= acc_pkg::SPILL_EMPTY;
          end
        end
        acc_pkg::SPILL_TWO: if (pop) state_q <= acc_pkg::SPILL_ONE;
        default: state_q <= acc_pkg::SPILL_EMPTY;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (state_q == acc_pkg::SPILL_TWO) begin
      if (pop) head_q <= tail_q;
    end else if (push) begin
      // Second entry parks in the tail unless the head drains now
      if (state_q == acc_pkg::SPILL_ONE && !pop) begin
        tail_q <= data_i;
      end else begin
        head_q <= data_i;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/acc_req_route.sv */
/*
 * Request side routing: per-requester level demux into the
 * next-level bypass or the local crossbar, then one round-robin
 * arbiter and spill register per accelerator
 */

`timescale 1ns/1ps
`default_nettype none

module acc_req_route (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,

  // From the requesters
  input  acc_pkg::c_req_t [acc_pkg::NUM_REQ-1:0]      c_req_i,
  input  logic            [acc_pkg::NUM_REQ-1:0]      c_req_valid_i,
  output logic            [acc_pkg::NUM_REQ-1:0]      c_req_ready_o,

  // Bypass towards the next level
  output acc_pkg::c_req_t [acc_pkg::NUM_REQ-1:0]      next_req_o,
  output logic            [acc_pkg::NUM_REQ-1:0]      next_req_valid_o,
  input  logic            [acc_pkg::NUM_REQ-1:0]      next_req_ready_i,

  // Towards the accelerators
  output acc_pkg::c_req_t [acc_pkg::NUM_RSP-1:0]      acc_req_o,
  output logic            [acc_pkg::NUM_RSP-1:0]      acc_req_valid_o,
  input  logic            [acc_pkg::NUM_RSP-1:0]      acc_req_ready_i
);

  acc_pkg::level_t   [acc_pkg::NUM_REQ-1:0]                       req_level;
  acc_pkg::rsp_sel_t [acc_pkg::NUM_REQ-1:0]                       req_sel;
  logic              [acc_pkg::NUM_REQ-1:0]                       req_local;

  // Per accelerator, per requester
  logic              [acc_pkg::NUM_RSP-1:0][acc_pkg::NUM_REQ-1:0] xbar_valid;
  logic              [acc_pkg::NUM_RSP-1:0][acc_pkg::NUM_REQ-1:0] xbar_ready;

  acc_pkg::c_req_t   [acc_pkg::NUM_RSP-1:0]                       arb_req;
  logic              [acc_pkg::NUM_RSP-1:0]                       arb_valid;
  logic              [acc_pkg::NUM_RSP-1:0]                       arb_ready;

  ////////////////////////////////////////
  // Level demux
  ////////////////////////////////////////

  for (genvar i = 0; i < acc_pkg::NUM_REQ; i++) begin : gen_demux
    assign req_level[i] =
      c_req_i[i].addr[acc_pkg::ADDR_WIDTH-1:acc_pkg::ACC_ADDR_WIDTH];
    assign req_sel[i]   = c_req_i[i].addr[acc_pkg::RSP_SEL_WIDTH-1:0];
    assign req_local[i] = (req_level[i] == acc_pkg::HIER_LEVEL);

    // Bypass is combinational, payload unchanged
    assign next_req_o[i]       = c_req_i[i];
    assign next_req_valid_o[i] = c_req_valid_i[i] && !req_local[i];

    assign c_req_ready_o[i] = req_local[i] ? xbar_ready[req_sel[i]][i]
                                           : next_req_ready_i[i];
  end

  // Mask local requests by their target accelerator
  always_comb begin
    for (int j = 0; j < acc_pkg::NUM_RSP; j++) begin
      for (int i = 0; i < acc_pkg::NUM_REQ; i++) begin
        xbar_valid[j][i] = c_req_valid_i[i] && req_local[i] && (req_sel[i] == j);
      end
    end
  end

  ////////////////////////////////////////
  // Crossbar outputs
  ////////////////////////////////////////

  for (genvar j = 0; j < acc_pkg::NUM_RSP; j++) begin : gen_acc
    acc_rr_arbiter #(
      .NUM_INP   (acc_pkg::NUM_REQ),
      .payload_t (acc_pkg::c_req_t)
    ) i_arb (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .inp_i       (c_req_i),
      .inp_valid_i (xbar_valid[j]),
      .inp_ready_o (xbar_ready[j]),
      .oup_o       (arb_req[j]),
      .oup_valid_o (arb_valid[j]),
      .oup_ready_i (arb_ready[j]),
      .oup_idx_o   ()
    );

    acc_spill_reg #(
      .payload_t (acc_pkg::c_req_t)
    ) i_spill (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (arb_req[j]),
      .valid_i (arb_valid[j]),
      .ready_o (arb_ready[j]),
      .data_o  (acc_req_o[j]),
      .valid_o (acc_req_valid_o[j]),
      .ready_i (acc_req_ready_i[j])
    );
  end

endmodule

`default_nettype wire

/* hw/acc_rsp_route.sv */
/*
 * Response side routing: hart id lookup steers accelerator results
 * to a requester, local results merge with next-level responses,
 * one spill register per requester output
 */

`timescale 1ns/1ps
`default_nettype none

module acc_rsp_route (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,

  // From the accelerators
  input  acc_pkg::c_rsp_t [acc_pkg::NUM_RSP-1:0]      acc_rsp_i,
  input  logic            [acc_pkg::NUM_RSP-1:0]      acc_rsp_valid_i,
  output logic            [acc_pkg::NUM_RSP-1:0]      acc_rsp_ready_o,

  // From the next level
  input  acc_pkg::c_rsp_t [acc_pkg::NUM_REQ-1:0]      next_rsp_i,
  input  logic            [acc_pkg::NUM_REQ-1:0]      next_rsp_valid_i,
  output logic            [acc_pkg::NUM_REQ-1:0]      next_rsp_ready_o,

  // Back to the requesters
  output acc_pkg::c_rsp_t [acc_pkg::NUM_REQ-1:0]      c_rsp_o,
  output logic            [acc_pkg::NUM_REQ-1:0]      c_rsp_valid_o,
  input  logic            [acc_pkg::NUM_REQ-1:0]      c_rsp_ready_i
);

  // Destination requester of each accelerator response
  acc_pkg::req_idx_t [acc_pkg::NUM_RSP-1:0]                       rsp_dest;

  // Per requester, per accelerator
  logic              [acc_pkg::NUM_REQ-1:0][acc_pkg::NUM_RSP-1:0] xbar_valid;
  logic              [acc_pkg::NUM_REQ-1:0][acc_pkg::NUM_RSP-1:0] xbar_ready;

  acc_pkg::c_rsp_t   [acc_pkg::NUM_REQ-1:0]                       loc_rsp;
  logic              [acc_pkg::NUM_REQ-1:0]                       loc_valid;
  logic              [acc_pkg::NUM_REQ-1:0]                       loc_ready;

  logic              [acc_pkg::NUM_REQ-1:0][1:0]                  merge_ready;
  acc_pkg::c_rsp_t   [acc_pkg::NUM_REQ-1:0]                       merge_rsp;
  logic              [acc_pkg::NUM_REQ-1:0]                       merge_valid;
  logic              [acc_pkg::NUM_REQ-1:0]                       spill_ready;

  ////////////////////////////////////////
  // Hart id lookup
  ////////////////////////////////////////

  // Constant table, so this folds into a few comparators
  always_comb begin
    for (int j = 0; j < acc_pkg::NUM_RSP; j++) begin
      rsp_dest[j] = '0;
      for (int i = 0; i < acc_pkg::NUM_REQ; i++) begin
        if (acc_rsp_i[j].hart_id == acc_pkg::HART_ID_TABLE[i]) begin
          rsp_dest[j] = acc_pkg::req_idx_t'(i);
        end
      end
      for (int i = 0; i < acc_pkg::NUM_REQ; i++) begin
        xbar_valid[i][j] = acc_rsp_valid_i[j] && (rsp_dest[j] == i);
      end
    end
  end

  for (genvar j = 0; j < acc_pkg::NUM_RSP; j++) begin : gen_acc_ready
    assign acc_rsp_ready_o[j] = xbar_ready[rsp_dest[j]][j];
  end

  ////////////////////////////////////////
  // Per requester merge
  ////////////////////////////////////////

  for (genvar i = 0; i < acc_pkg::NUM_REQ; i++) begin : gen_req
    acc_rr_arbiter #(
      .NUM_INP   (acc_pkg::NUM_RSP),
      .payload_t (acc_pkg::c_rsp_t)
    ) i_loc_arb (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .inp_i       (acc_rsp_i),
      .inp_valid_i (xbar_valid[i]),
      .inp_ready_o (xbar_ready[i]),
      .oup_o       (loc_rsp[i]),
      .oup_valid_o (loc_valid[i]),
      .oup_ready_i (loc_ready[i]),
      .oup_idx_o   ()
    );

    // Input 0 local, input 1 next level
    acc_rr_arbiter #(
      .NUM_INP   (2),
      .payload_t (acc_pkg::c_rsp_t)
    ) i_merge_arb (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .inp_i       ({next_rsp_i[i], loc_rsp[i]}),
      .inp_valid_i ({next_rsp_valid_i[i], loc_valid[i]}),
      .inp_ready_o (merge_ready[i]),
      .oup_o       (merge_rsp[i]),
      .oup_valid_o (merge_valid[i]),
      .oup_ready_i (spill_ready[i]),
      .oup_idx_o   ()
    );

    assign loc_ready[i]        = merge_ready[i][0];
    assign next_rsp_ready_o[i] = merge_ready[i][1];

    acc_spill_reg #(
      .payload_t (acc_pkg::c_rsp_t)
    ) i_spill (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (merge_rsp[i]),
      .valid_i (merge_valid[i]),
      .ready_o (spill_ready[i]),
      .data_o  (c_rsp_o[i]),
      .valid_o (c_rsp_valid_o[i]),
      .ready_i (c_rsp_ready_i[i])
    );
  end

endmodule

`default_nettype wire

/* hw/acc_interconnect.sv */
/*
 * One hierarchy level of the accelerator offload interconnect,
 * C channel only: request routing and response routing
 */

`timescale 1ns/1ps
`default_nettype none

module acc_interconnect (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,

  // Requester side
  input  acc_pkg::c_req_t [acc_pkg::NUM_REQ-1:0] c_req_i,
  input  logic            [acc_pkg::NUM_REQ-1:0] c_req_valid_i,
  output logic            [acc_pkg::NUM_REQ-1:0] c_req_ready_o,
  output acc_pkg::c_rsp_t [acc_pkg::NUM_REQ-1:0] c_rsp_o,
  output logic            [acc_pkg::NUM_REQ-1:0] c_rsp_valid_o,
  input  logic            [acc_pkg::NUM_REQ-1:0] c_rsp_ready_i,

  // Next level
  output acc_pkg::c_req_t [acc_pkg::NUM_REQ-1:0] next_req_o,
  output logic            [acc_pkg::NUM_REQ-1:0] next_req_valid_o,
  input  logic            [acc_pkg::NUM_REQ-1:0] next_req_ready_i,
  input  acc_pkg::c_rsp_t [acc_pkg::NUM_REQ-1:0] next_rsp_i,
  input  logic            [acc_pkg::NUM_REQ-1:0] next_rsp_valid_i,
  output logic            [acc_pkg::NUM_REQ-1:0] next_rsp_ready_o,

  // Accelerator units
  output acc_pkg::c_req_t [acc_pkg::NUM_RSP-1:0] acc_req_o,
  output logic            [acc_pkg::NUM_RSP-1:0] acc_req_valid_o,
  input  logic            [acc_pkg::NUM_RSP-1:0] acc_req_ready_i,
  input  acc_pkg::c_rsp_t [acc_pkg::NUM_RSP-1:0] acc_rsp_i,
  input  logic            [acc_pkg::NUM_RSP-1:0] acc_rsp_valid_i,
  output logic            [acc_pkg::NUM_RSP-1:0] acc_rsp_ready_o
);

  acc_req_route i_req_route (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .c_req_i          (c_req_i),
    .c_req_valid_i    (c_req_valid_i),
    .c_req_ready_o    (c_req_ready_o),
    .next_req_o       (next_req_o),
    .next_req_valid_o (next_req_valid_o),
    .next_req_ready_i (next_req_ready_i),
    .acc_req_o        (acc_req_o),
    .acc_req_valid_o  (acc_req_valid_o),
    .acc_req_ready_i  (acc_req_ready_i)
  );

  acc_rsp_route i_rsp_route (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .acc_rsp_i        (acc_rsp_i),
    .acc_rsp_valid_i  (acc_rsp_valid_i),
    .acc_rsp_ready_o  (acc_rsp_ready_o),
    .next_rsp_i       (next_rsp_i),
    .next_rsp_valid_i (next_rsp_valid_i),
    .next_rsp_ready_o (next_rsp_ready_o),
    .c_rsp_o          (c_rsp_o),
    .c_rsp_valid_o    (c_rsp_valid_o),
    .c_rsp_ready_i    (c_rsp_ready_i)
  );

endmodule

`default_nettype wire

/* tb/acc_interconnect_sva.sv */
/*
 * Stream stability and level routing assertions,
 * bound to the interconnect top level
 */

`timescale 1ns/1ps
`default_nettype none

module acc_interconnect_sva (
  input logic                                   clk_i,
  input logic                                   rst_n_i,
  input acc_pkg::c_req_t [acc_pkg::NUM_RSP-1:0] acc_req_o,
  input logic            [acc_pkg::NUM_RSP-1:0] acc_req_valid_o,
  input logic            [acc_pkg::NUM_RSP-1:0] acc_req_ready_i,
  input acc_pkg::c_req_t [acc_pkg::NUM_REQ-1:0] next_req_o,
  input logic            [acc_pkg::NUM_REQ-1:0] next_req_valid_o,
  input logic            [acc_pkg::NUM_REQ-1:0] next_req_ready_i,
  input acc_pkg::c_rsp_t [acc_pkg::NUM_REQ-1:0] c_rsp_o,
  input logic            [acc_pkg::NUM_REQ-1:0] c_rsp_valid_o,
  input logic            [acc_pkg::NUM_REQ-1:0] c_rsp_ready_i
);

  localparam acc_pkg::level_t LOCAL_LEVEL = acc_pkg::level_t'(acc_pkg::HIER_LEVEL);

  for (genvar j = 0; j < acc_pkg::NUM_RSP; j++) begin : gen_acc
    acc_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      acc_req_valid_o[j] && !acc_req_ready_i[j] |=>
        acc_req_valid_o[j] && $stable(acc_req_o[j]))
      else $error("accelerator %0d request changed before ready", j);

    acc_req_local: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      acc_req_valid_o[j] |->
        acc_req_o[j].addr[acc_pkg::ADDR_WIDTH-1:acc_pkg::ACC_ADDR_WIDTH] == LOCAL_LEVEL)
      else $error("accelerator %0d got a request of another level", j);
  end

  for (genvar i = 0; i < acc_pkg::NUM_REQ; i++) begin : gen_req
    next_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      next_req_valid_o[i] && !next_req_ready_i[i] |=>
        next_req_valid_o[i] && $stable(next_req_o[i]))
      else $error("next level %0d request changed before ready", i);

    next_req_remote: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      next_req_valid_o[i] |->
        next_req_o[i].addr[acc_pkg::ADDR_WIDTH-1:acc_pkg::ACC_ADDR_WIDTH] != LOCAL_LEVEL)
      else $error("next level %0d got a local request", i);

    c_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      c_rsp_valid_o[i] && !c_rsp_ready_i[i] |=> c_rsp_valid_o[i] && $stable(c_rsp_o[i]))
      else $error("requester %0d response changed before ready", i);
  end

endmodule

bind acc_interconnect acc_interconnect_sva i_sva (.*);

`default_nettype wire

/* tb/tb_acc_interconnect.sv */
/*
 * Testbench for the accelerator offload interconnect: file driven
 * requesters, accelerator and next-level models, per source and
 * destination scoreboards, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module tb_acc_interconnect;

  localparam int MAX_REC = 64;
  localparam int REC_W   = 6;
  localparam int NR      = acc_pkg::NUM_REQ;
  localparam int NA      = acc_pkg::NUM_RSP;

  logic                        clk_i;
  logic                        rst_n_i;
  acc_pkg::c_req_t [NR-1:0]    c_req_i;
  logic            [NR-1:0]    c_req_valid_i;
  logic            [NR-1:0]    c_req_ready_o;
  acc_pkg::c_rsp_t [NR-1:0]    c_rsp_o;
  logic            [NR-1:0]    c_rsp_valid_o;
  logic            [NR-1:0]    c_rsp_ready_i;
  acc_pkg::c_req_t [NR-1:0]    next_req_o;
  logic            [NR-1:0]    next_req_valid_o;
  logic            [NR-1:0]    next_req_ready_i;
  acc_pkg::c_rsp_t [NR-1:0]    next_rsp_i;
  logic            [NR-1:0]    next_rsp_valid_i;
  logic            [NR-1:0]    next_rsp_ready_o;
  acc_pkg::c_req_t [NA-1:0]    acc_req_o;
  logic            [NA-1:0]    acc_req_valid_o;
  logic            [NA-1:0]    acc_req_ready_i;
  acc_pkg::c_rsp_t [NA-1:0]    acc_rsp_i;
  logic            [NA-1:0]    acc_rsp_valid_i;
  logic            [NA-1:0]    acc_rsp_ready_o;

  integer      seed = 32'hacd1_391e;
  logic [31:0] stim_mem [0:MAX_REC*REC_W-1];
  int          num_rec;
  int          req_errors;
  int          rsp_errors;
  int          other_errors;
  bit          stim_loaded;
  logic [NR-1:0] req_fire;
  logic [NR-1:0] nrsp_fire;
  logic [NA-1:0] accrsp_fire;

  // Driver queues and model state
  acc_pkg::c_req_t req_q  [NR][$];
  acc_pkg::c_rsp_t nrsp_q [NR][$];
  acc_pkg::c_rsp_t pend_q [NA][$];

  // Expected traffic, one queue per source and destination pair
  acc_pkg::c_req_t exp_acc_q  [NA*NR][$];
  acc_pkg::c_req_t exp_next_q [NR][$];
  acc_pkg::c_rsp_t exp_rsp_q  [NR*(NA+1)][$];

  acc_interconnect UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_req(input acc_pkg::c_req_t got, input acc_pkg::c_req_t exp,
                           input string where);
    if (got !== exp) begin
      req_errors++;
      $display("[FAIL] %0d ns: %s got request %h, expected %h", $time, where, got, exp);
    end
  endtask

  task automatic check_rsp(input acc_pkg::c_rsp_t got, input acc_pkg::c_rsp_t exp,
                           input string where);
    if (got !== exp) begin
      rsp_errors++;
      $display("[FAIL] %0d ns: %s got response %h, expected %h", $time, where, got, exp);
    end
  endtask

  task automatic check_idle(input logic [NR-1:0] rsp_v, input logic [NR-1:0] nxt_v,
                            input logic [NA-1:0] acc_v);
    if (rsp_v !== '0 || nxt_v !== '0 || acc_v !== '0) begin
      other_errors++;
      $display("[FAIL] %0d ns: valid output high after reset (%b %b %b)",
               $time, rsp_v, nxt_v, acc_v);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////

  task automatic load_stim();
    acc_pkg::c_req_t req;
    acc_pkg::c_rsp_t rsp;
    int base;
    int i;
    int route;
    for (int n = 0; n < MAX_REC*REC_W; n++) stim_mem[n] = '0;
    $readmemh("tb/acc_stim.txt", stim_mem);
    num_rec = 0;
    while (num_rec < MAX_REC && stim_mem[num_rec*REC_W] != 0) begin
      base  = num_rec * REC_W;
      i     = int'(stim_mem[base+1]);
      route = int'(stim_mem[base+2]);
      if (i >= NR || (route >= NA && route != 15)) begin
        other_errors++;
        $display("Stimulus record %0d has a bad requester or route", num_rec);
      end else if (stim_mem[base] == 1) begin
        req.addr    = acc_pkg::addr_t'(stim_mem[base+3]);
        req.hart_id = acc_pkg::hart_id_t'(acc_pkg::HART_ID_BASE + i);
        req.instr   = stim_mem[base+4];
        req.rs1     = stim_mem[base+5];
        req_q[i].push_back(req);
        if (route == 15) begin
          exp_next_q[i].push_back(req);
        end else begin
          exp_acc_q[route*NR+i].push_back(req);
          // Accelerator answer is instr XOR rs1 for the issuing hart
          rsp.hart_id = req.hart_id;
          rsp.result  = req.instr ^ req.rs1;
          rsp.error   = 1'b0;
          exp_rsp_q[i*(NA+1)+route].push_back(rsp);
        end
      end else begin
        rsp.hart_id = acc_pkg::hart_id_t'(acc_pkg::HART_ID_BASE + i);
        rsp.result  = stim_mem[base+4];
        rsp.error   = 1'b0;
        nrsp_q[i].push_back(rsp);
        exp_rsp_q[i*(NA+1)+NA].push_back(rsp);
      end
      num_rec++;
    end
    if (num_rec == 0) begin
      other_errors++;
      $display("No stimulus records were read");
    end
  endtask

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  task automatic got_acc(input int j, input acc_pkg::c_req_t got);
    acc_pkg::c_req_t exp;
    acc_pkg::c_rsp_t rsp;
    int src;
    src = int'(got.hart_id) - int'(acc_pkg::HART_ID_BASE);
    if (src < 0 || src >= NR || exp_acc_q[j*NR+src].size() == 0) begin
      req_errors++;
      $display("[FAIL] %0d ns: unexpected request %h at accelerator %0d", $time, got, j);
    end else begin
      exp = exp_acc_q[j*NR+src].pop_front();
      check_req(got, exp, $sformatf("accelerator %0d", j));
    end
    // Accelerator model queues its answer
    rsp.hart_id = got.hart_id;
    rsp.result  = got.instr ^ got.rs1;
    rsp.error   = 1'b0;
    pend_q[j].push_back(rsp);
  endtask

  task automatic got_next(input int i, input acc_pkg::c_req_t got);
    acc_pkg::c_req_t exp;
    if (exp_next_q[i].size() == 0) begin
      req_errors++;
      $display("[FAIL] %0d ns: unexpected request %h at next level %0d", $time, got, i);
    end else begin
      exp = exp_next_q[i].pop_front();
      check_req(got, exp, $sformatf("next level %0d", i));
    end
  endtask

  task automatic got_rsp(input int i, input acc_pkg::c_rsp_t got);
    acc_pkg::c_rsp_t exp;
    int base;
    int hit;
    int first;
    base  = i * (NA + 1);
    hit   = -1;
    first = -1;
    // Sources interleave freely, so match against each queue head
    for (int s = 0; s <= NA; s++) begin
      if (exp_rsp_q[base+s].size() > 0) begin
        if (first < 0) first = s;
        if (hit < 0 && exp_rsp_q[base+s][0] === got) hit = s;
      end
    end
    if (hit >= 0) begin
      exp = exp_rsp_q[base+hit].pop_front();
    end else if (first < 0) begin
      rsp_errors++;
      $display("[FAIL] %0d ns: unexpected response %h at requester %0d", $time, got, i);
    end else begin
      exp = exp_rsp_q[base+first].pop_front();
      check_rsp(got, exp, $sformatf("requester %0d", i));
    end
  endtask

  ////////////////////////////////////////
  // Cycle stepping
  ////////////////////////////////////////

  task automatic advance();
    for (int i = 0; i < NR; i++) begin
      if (req_fire[i]) void'(req_q[i].pop_front());
      if (nrsp_fire[i]) void'(nrsp_q[i].pop_front());
      c_req_valid_i[i] = (req_q[i].size() > 0);
      if (c_req_valid_i[i]) c_req_i[i] = req_q[i][0];
      next_rsp_valid_i[i] = (nrsp_q[i].size() > 0);
      if (next_rsp_valid_i[i]) next_rsp_i[i] = nrsp_q[i][0];
      next_req_ready_i[i] = (($random(seed) & 3) != 0);
      c_rsp_ready_i[i]    = (($random(seed) & 3) != 0);
    end
    for (int j = 0; j < NA; j++) begin
      if (accrsp_fire[j]) void'(pend_q[j].pop_front());
      acc_rsp_valid_i[j] = (pend_q[j].size() > 0);
      if (acc_rsp_valid_i[j]) acc_rsp_i[j] = pend_q[j][0];
      acc_req_ready_i[j] = (($random(seed) & 3) != 0);
    end
  endtask

  // Values here hold until the next rising edge
  task automatic sample();
    for (int i = 0; i < NR; i++) begin
      req_fire[i]  = c_req_valid_i[i] && c_req_ready_o[i];
      nrsp_fire[i] = next_rsp_valid_i[i] && next_rsp_ready_o[i];
      if (next_req_valid_o[i] && next_req_ready_i[i]) got_next(i, next_req_o[i]);
      if (c_rsp_valid_o[i] && c_rsp_ready_i[i]) got_rsp(i, c_rsp_o[i]);
    end
    for (int j = 0; j < NA; j++) begin
      accrsp_fire[j] = acc_rsp_valid_i[j] && acc_rsp_ready_o[j];
      if (acc_req_valid_o[j] && acc_req_ready_i[j]) got_acc(j, acc_req_o[j]);
    end
  endtask

  task automatic step();
    @(negedge clk_i);
    advance();
    #1;
    sample();
  endtask

  function automatic bit all_done();
    bit done;
    done = 1'b1;
    for (int i = 0; i < NR; i++) begin
      if (req_q[i].size() > 0 || nrsp_q[i].size() > 0) done = 1'b0;
      if (exp_next_q[i].size() > 0) done = 1'b0;
    end
    for (int j = 0; j < NA; j++) begin
      if (pend_q[j].size() > 0) done = 1'b0;
    end
    for (int k = 0; k < NA*NR; k++) begin
      if (exp_acc_q[k].size() > 0) done = 1'b0;
    end
    for (int k = 0; k < NR*(NA+1); k++) begin
      if (exp_rsp_q[k].size() > 0) done = 1'b0;
    end
    return done;
  endfunction

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    rst_n_i          = 1'b0;
    c_req_i          = '0;
    c_req_valid_i    = '0;
    c_rsp_ready_i    = '0;
    next_req_ready_i = '0;
    next_rsp_i       = '0;
    next_rsp_valid_i = '0;
    acc_req_ready_i  = '0;
    acc_rsp_i        = '0;
    acc_rsp_valid_i  = '0;
    req_fire         = '0;
    nrsp_fire        = '0;
    accrsp_fire      = '0;
    req_errors       = 0;
    rsp_errors       = 0;
    other_errors     = 0;
    load_stim();
    stim_loaded = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_idle(c_rsp_valid_o, next_req_valid_o, acc_req_valid_o);
    while (!all_done()) step();
    // Short drain to catch stray transfers
    repeat (8) step();
    $display("Error counts: request %0d, response %0d, other %0d",
             req_errors, rsp_errors, other_errors);
    if (req_errors + rsp_errors + other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (stim_loaded);
    repeat ((num_rec + 1) * 200) @(posedge clk_i);
    $display("Watchdog expired with transfers still outstanding");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/acc_stim.txt */
// Columns: kind req route addr instr rs1, all hex, one record per line
// kind 1 request, kind 2 next-level response with its result in instr; route F is next level
// One local request per accelerator
1 0 0 40 00000013 000000a5
1 1 1 41 00100093 5a5a0000
// Other levels bypass to the next level
1 0 F 00 0000702b 12345678
1 1 F 81 deadbeef 00000001
1 0 F c2 cafe0000 0000f00d
// Responses from the next level
2 0 F 00 11110000 00000000
2 1 F 00 22220000 00000000
// Both requesters contend for accelerator 0
1 0 0 42 a0000001 0000000f
1 1 0 44 b0000002 000000f0
1 0 0 46 a0000003 00000f00
1 1 0 48 b0000004 0000f000
1 0 0 7e a0000005 000f0000
1 1 0 60 b0000006 00f00000
1 0 0 50 a0000007 0f000000
1 1 0 52 b0000008 f0000000
// Mixed local, bypass and next-level traffic
1 0 1 43 c0000001 01010101
2 0 F 00 33330000 00000000
1 1 F 3f d0000002 02020202
1 1 1 7f c0000003 03030303
2 1 F 00 44440000 00000000
1 0 F bf d0000004 04040404
1 1 0 4a c0000005 05050505
2 0 F 00 55550000 00000000
1 0 1 65 c0000006 06060606
2 1 F 00 66660000 00000000
1 1 1 59 c0000007 07070707
1 0 F 80 e0000008 08080808
1 1 0 56 c0000009 09090909

/* acc_interconnect.f */
hw/acc_pkg.sv
hw/acc_rr_arbiter.sv
hw/acc_spill_reg.sv
hw/acc_req_route.sv
hw/acc_rsp_route.sv
hw/acc_interconnect.sv
tb/acc_interconnect_sva.sv
tb/tb_acc_interconnect.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_acc_interconnect
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f acc_interconnect.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1
